/* source/ofdm_pkg.sv */
package ofdm_pkg;

    // decode states of the cyclic-prefix remover
    typedef enum logic [1:0] {
        CP_SKIP   = 2'd0,
        CP_SYMBOL = 2'd1,
        CP_TAIL   = 2'd2
    } cp_state_t;

    // transform engine states
    typedef enum logic [1:0] {
        DFT_IDLE = 2'd0,
        DFT_LOAD = 2'd1,
        DFT_CALC = 2'd2
    } dft_state_t;

    // role of a symbol within the frame
    typedef enum logic [1:0] {
        SYM_DATA = 2'd0,
        SYM_PBCH = 2'd1,
        SYM_SSS  = 2'd2
    } sym_kind_t;

    // frame structure
    localparam int SYM_PER_SLOT    = 14;
    localparam int SLOTS_PER_FRAME = 20;

    // field widths
    localparam int SYM_W  = 4;
    localparam int SLOT_W = 5;
    localparam int CP_W   = 8;

    // synchronisation block symbols within slot 0
    localparam int PBCH_SYM = 3;
    localparam int SSS_SYM  = 4;

    // fraction bits of the twiddle values
    localparam int TW_FRAC = 14;

endpackage

/* source/cp_remover.sv */
`timescale 1ns/1ps

module cp_remover #(
    parameter int NFFT     = 4,
    parameter int SAMPLE_W = 16
) (
    input  logic                        clk_i,
    input  logic                        reset_ni,
    input  logic [SAMPLE_W-1:0]         sample_re_i,
    input  logic [SAMPLE_W-1:0]         sample_im_i,
    input  logic                        sample_valid_i,
    input  logic [ofdm_pkg::CP_W-1:0]   cp_len_i,
    input  logic                        sync_i,
    output logic [SAMPLE_W-1:0]         sym_re_o,
    output logic [SAMPLE_W-1:0]         sym_im_o,
    output logic                        sym_valid_o,
    output logic [ofdm_pkg::SLOT_W-1:0] sym_slot_o,
    output logic [ofdm_pkg::SYM_W-1:0]  sym_idx_o
);

    localparam int FFT_LEN = 2 ** NFFT;

    ofdm_pkg::cp_state_t state_q;

    logic [ofdm_pkg::CP_W-1:0]   cp_cnt_q;
    logic [ofdm_pkg::CP_W-1:0]   cp_len_q;
    logic [NFFT-1:0]             smp_cnt_q;
    logic [ofdm_pkg::SLOT_W-1:0] slot_q;
    logic [ofdm_pkg::SYM_W-1:0]  idx_q;

    // a new symbol begins at the boundary state or on a fresh CP count
    logic                        sym_start;
    logic                        cp_done;
    logic                        fwd;
    logic                        last_smp;

    assign sym_start = (state_q == ofdm_pkg::CP_TAIL) ||
                       ((state_q == ofdm_pkg::CP_SKIP) && (cp_cnt_q == '0));
    // the first sample of a symbol still sees cp_len_i directly
    assign cp_done   = sym_start ? (cp_len_i == '0) : (cp_cnt_q == cp_len_q);

    assign fwd      = sample_valid_i && !sync_i &&
                      ((state_q == ofdm_pkg::CP_SYMBOL) || cp_done);
    assign last_smp = fwd && (state_q == ofdm_pkg::CP_SYMBOL) &&
                      (smp_cnt_q == NFFT'(FFT_LEN - 1));

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q   <= ofdm_pkg::CP_SKIP;
            cp_cnt_q  <= '0;
            cp_len_q  <= '0;
            smp_cnt_q <= '0;
            slot_q    <= '0;
            idx_q     <= '0;
        end else if (sync_i) begin
            // frame start restarts the CP count and the numbering
            state_q   <= ofdm_pkg::CP_SKIP;
            cp_cnt_q  <= '0;
            smp_cnt_q <= '0;
            slot_q    <= '0;
            idx_q     <= '0;
        end else if (sample_valid_i) begin
            case (state_q)
                ofdm_pkg::CP_SKIP, ofdm_pkg::CP_TAIL: begin
                    if (sym_start) begin
                        cp_len_q <= cp_len_i;
                    end
                    if (cp_done) begin
                        // this sample is already the first one of the symbol
                        state_q   <= ofdm_pkg::CP_SYMBOL;
                        smp_cnt_q <= NFFT'(1);
                        cp_cnt_q  <= '0;
                    end else begin
                        state_q  <= ofdm_pkg::CP_SKIP;
                        cp_cnt_q <= sym_start ? ofdm_pkg::CP_W'(1) : cp_cnt_q + 1'b1;
                    end
                end
                ofdm_pkg::CP_SYMBOL: begin
                    smp_cnt_q <= smp_cnt_q + 1'b1;
                    if (last_smp) begin
                        state_q  <= ofdm_pkg::CP_TAIL;
                        cp_cnt_q <= '0;
                        if (idx_q == ofdm_pkg::SYM_W'(ofdm_pkg::SYM_PER_SLOT - 1)) begin
                            idx_q <= '0;
                            if (slot_q == ofdm_pkg::SLOT_W'(ofdm_pkg::SLOTS_PER_FRAME - 1)) begin
                                slot_q <= '0;
                            end else begin
                                slot_q <= slot_q + 1'b1;
                            end
                        end else begin
                            idx_q <= idx_q + 1'b1;
                        end
                    end
                end
                default: begin
                    state_q <= ofdm_pkg::CP_SKIP;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            sym_valid_o <= 1'b0;
        end else begin
            sym_valid_o <= fwd;
        end
    end

    // payload and numbering of the forwarded sample
    always_ff @(posedge clk_i) begin
        if (fwd) begin
            sym_re_o   <= sample_re_i;
            sym_im_o   <= sample_im_i;
            sym_slot_o <= slot_q;
            sym_idx_o  <= idx_q;
        end
    end

endmodule

/* source/dft_engine.sv */
`timescale 1ns/1ps

module dft_engine #(
    parameter int NFFT     = 4,
    parameter int SAMPLE_W = 16
) (
    input  logic                        clk_i,
    input  logic                        reset_ni,
    input  logic [SAMPLE_W-1:0]         sym_re_i,
    input  logic [SAMPLE_W-1:0]         sym_im_i,
    input  logic                        sym_valid_i,
    input  logic [ofdm_pkg::SLOT_W-1:0] sym_slot_i,
    input  logic [ofdm_pkg::SYM_W-1:0]  sym_idx_i,
    output logic [SAMPLE_W-1:0]         bin_re_o,
    output logic [SAMPLE_W-1:0]         bin_im_o,
    output logic                        bin_valid_o,
    output logic [NFFT-1:0]             bin_pos_o,
    output logic [ofdm_pkg::SLOT_W-1:0] bin_slot_o,
    output logic [ofdm_pkg::SYM_W-1:0]  bin_idx_o,
    output logic                        overrun_o
);

    localparam int  FFT_LEN = 2 ** NFFT;
    localparam int  TW_W    = ofdm_pkg::TW_FRAC + 2;
    localparam int  PH_W    = NFFT + 1;
    localparam int  ACC_W   = SAMPLE_W + TW_W + 1 + NFFT;
    localparam int  SHIFT   = ofdm_pkg::TW_FRAC + NFFT;
    localparam real PI      = 3.14159265358979;

    // round to nearest, symmetric around zero
    function automatic logic signed [TW_W-1:0] tw_round(input real v);
        real scaled;
        scaled = v * real'((2 ** ofdm_pkg::TW_FRAC) - 1);
        if (scaled >= 0.0) begin
            return TW_W'($rtoi(scaled + 0.5));
        end
        return -TW_W'($rtoi(-scaled + 0.5));
    endfunction

    ofdm_pkg::dft_state_t state_q;

    logic signed [SAMPLE_W-1:0] buf_re [FFT_LEN];
    logic signed [SAMPLE_W-1:0] buf_im [FFT_LEN];
    logic signed [TW_W-1:0]     tw_re  [FFT_LEN];
    logic signed [TW_W-1:0]     tw_im  [FFT_LEN];

    logic [NFFT-1:0]            wr_cnt_q;
    logic                       drop_q;
    logic [PH_W-1:0]            ph_q;
    logic [NFFT-1:0]            pos_q;
    logic [NFFT-1:0]            bin_k;
    logic [NFFT-1:0]            tw_idx;
    logic                       load_en;

    logic signed [SAMPLE_W-1:0] op_a_q;
    logic signed [SAMPLE_W-1:0] op_b_q;
    logic signed [TW_W-1:0]     op_c_q;
    logic signed [TW_W-1:0]     op_d_q;
    logic                       mac_en_q;
    logic                       first_q;
    logic signed [ACC_W-1:0]    acc_re_q;
    logic signed [ACC_W-1:0]    acc_im_q;
    logic signed [ACC_W-1:0]    prod_re;
    logic signed [ACC_W-1:0]    prod_im;
    logic signed [ACC_W-1:0]    acc_re_sh;
    logic signed [ACC_W-1:0]    acc_im_sh;

    // twiddle table holds cos and -sin of 2*pi*i/N
    for (genvar i = 0; i < FFT_LEN; i++) begin : g_tw
        assign tw_re[i] = tw_round($cos(2.0 * PI * i / FFT_LEN));
        assign tw_im[i] = tw_round(-$sin(2.0 * PI * i / FFT_LEN));
    end

    // shifted order, position 0 is the most negative frequency
    assign bin_k  = pos_q + NFFT'(FFT_LEN / 2);
    assign tw_idx = NFFT'(bin_k * ph_q[NFFT-1:0]);

    assign load_en = sym_valid_i &&
                     (((state_q == ofdm_pkg::DFT_IDLE) && !drop_q) ||
                      (state_q == ofdm_pkg::DFT_LOAD));

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q     <= ofdm_pkg::DFT_IDLE;
            wr_cnt_q    <= '0;
            drop_q      <= 1'b0;
            overrun_o   <= 1'b0;
            ph_q        <= '0;
            pos_q       <= '0;
            mac_en_q    <= 1'b0;
            bin_valid_o <= 1'b0;
        end else begin
            overrun_o   <= 1'b0;
            bin_valid_o <= 1'b0;
            mac_en_q    <= (state_q == ofdm_pkg::DFT_CALC) && (ph_q < PH_W'(FFT_LEN));

            if (sym_valid_i) begin
                wr_cnt_q <= wr_cnt_q + 1'b1;
                // a symbol starting during the transform is thrown away
                if ((wr_cnt_q == '0) && (state_q == ofdm_pkg::DFT_CALC)) begin
                    drop_q <= 1'b1;
                end
                if (drop_q && (wr_cnt_q == NFFT'(FFT_LEN - 1))) begin
                    drop_q    <= 1'b0;
                    overrun_o <= 1'b1;
                end
            end

            case (state_q)
                ofdm_pkg::DFT_IDLE: begin
                    if (load_en) begin
                        state_q <= ofdm_pkg::DFT_LOAD;
                    end
                end
                ofdm_pkg::DFT_LOAD: begin
                    if (sym_valid_i && (wr_cnt_q == NFFT'(FFT_LEN - 1))) begin
                        state_q <= ofdm_pkg::DFT_CALC;
                        ph_q    <= '0;
                        pos_q   <= '0;
                    end
                end
                ofdm_pkg::DFT_CALC: begin
                    if (ph_q == PH_W'(FFT_LEN + 1)) begin
                        ph_q        <= '0;
                        pos_q       <= pos_q + 1'b1;
                        bin_valid_o <= 1'b1;
                        if (pos_q == NFFT'(FFT_LEN - 1)) begin
                            state_q <= ofdm_pkg::DFT_IDLE;
                        end
                    end else begin
                        ph_q <= ph_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= ofdm_pkg::DFT_IDLE;
                end
            endcase
        end
    end

    // sample buffer and symbol metadata
    always_ff @(posedge clk_i) begin
        if (load_en) begin
            buf_re[wr_cnt_q] <= sym_re_i;
            buf_im[wr_cnt_q] <= sym_im_i;
            if (state_q == ofdm_pkg::DFT_IDLE) begin
                bin_slot_o <= sym_slot_i;
                bin_idx_o  <= sym_idx_i;
            end
        end
    end

    // (a + jb)(c + jd) accumulated over n
    assign prod_re = ACC_W'(op_a_q * op_c_q) - ACC_W'(op_b_q * op_d_q);
    assign prod_im = ACC_W'(op_a_q * op_d_q) + ACC_W'(op_b_q * op_c_q);

    assign acc_re_sh = acc_re_q >>> SHIFT;
    assign acc_im_sh = acc_im_q >>> SHIFT;

    always_ff @(posedge clk_i) begin
        op_a_q  <= buf_re[ph_q[NFFT-1:0]];
        op_b_q  <= buf_im[ph_q[NFFT-1:0]];
        op_c_q  <= tw_re[tw_idx];
        op_d_q  <= tw_im[tw_idx];
        first_q <= (ph_q == '0);
        if (mac_en_q) begin
            acc_re_q <= (first_q ? '0 : acc_re_q) + prod_re;
            acc_im_q <= (first_q ? '0 : acc_im_q) + prod_im;
        end
        if ((state_q == ofdm_pkg::DFT_CALC) && (ph_q == PH_W'(FFT_LEN + 1))) begin
            bin_re_o  <= acc_re_sh[SAMPLE_W-1:0];
            bin_im_o  <= acc_im_sh[SAMPLE_W-1:0];
            bin_pos_o <= pos_q;
        end
    end

endmodule

/* source/sc_mapper.sv */
`timescale 1ns/1ps

module sc_mapper #(
    parameter int NFFT     = 4,
    parameter int SAMPLE_W = 16,
    parameter int BAND_LEN = 12,
    parameter int SSS_LEN  = 8
) (
    input  logic                        clk_i,
    input  logic                        reset_ni,
    input  logic [SAMPLE_W-1:0]         bin_re_i,
    input  logic [SAMPLE_W-1:0]         bin_im_i,
    input  logic                        bin_valid_i,
    input  logic [NFFT-1:0]             bin_pos_i,
    input  logic [ofdm_pkg::SLOT_W-1:0] bin_slot_i,
    input  logic [ofdm_pkg::SYM_W-1:0]  bin_idx_i,
    output logic [SAMPLE_W-1:0]         sc_re_o,
    output logic [SAMPLE_W-1:0]         sc_im_o,
    output logic                        sc_valid_o,
    output logic                        sc_last_o,
    output ofdm_pkg::sym_kind_t         sc_kind_o,
    output logic [ofdm_pkg::SLOT_W-1:0] sc_slot_o,
    output logic [ofdm_pkg::SYM_W-1:0]  sc_idx_o
);

    localparam int HALF       = 2 ** (NFFT - 1);
    localparam int BAND_START = HALF - BAND_LEN / 2;
    localparam int BAND_END   = BAND_START + BAND_LEN - 1;
    localparam int SSS_START  = HALF - SSS_LEN / 2;
    localparam int SSS_END    = SSS_START + SSS_LEN - 1;

    logic                in_band;
    logic                in_sss;
    logic                is_pbch_sym;
    logic                is_sss_sym;
    ofdm_pkg::sym_kind_t kind;

    // windows are centred on the DC position
    assign in_band = (bin_pos_i >= NFFT'(BAND_START)) && (bin_pos_i <= NFFT'(BAND_END));
    assign in_sss  = (bin_pos_i >= NFFT'(SSS_START)) && (bin_pos_i <= NFFT'(SSS_END));

    assign is_pbch_sym = (bin_slot_i == '0) &&
                         (bin_idx_i == ofdm_pkg::SYM_W'(ofdm_pkg::PBCH_SYM));
    assign is_sss_sym  = (bin_slot_i == '0) &&
                         (bin_idx_i == ofdm_pkg::SYM_W'(ofdm_pkg::SSS_SYM));

    always_comb begin
        kind = ofdm_pkg::SYM_DATA;
        if (is_pbch_sym) begin
            kind = ofdm_pkg::SYM_PBCH;
        end else if (is_sss_sym && in_sss) begin
            // SSS occupies only the centre of the band
            kind = ofdm_pkg::SYM_SSS;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            sc_valid_o <= 1'b0;
            sc_last_o  <= 1'b0;
        end else begin
            sc_valid_o <= bin_valid_i && in_band;
            sc_last_o  <= bin_valid_i && (bin_pos_i == NFFT'(BAND_END));
        end
    end

    always_ff @(posedge clk_i) begin
        if (bin_valid_i && in_band) begin
            sc_re_o   <= bin_re_i;
            sc_im_o   <= bin_im_i;
            sc_kind_o <= kind;
            sc_slot_o <= bin_slot_i;
            sc_idx_o  <= bin_idx_i;
        end
    end

endmodule

/* source/ofdm_demod.sv */
`timescale 1ns/1ps

module ofdm_demod #(
    parameter int NFFT     = 4,
    parameter int SAMPLE_W = 16,
    parameter int BAND_LEN = 12,
    parameter int SSS_LEN  = 8
) (
    input  logic                        clk_i,
    input  logic                        reset_ni,
    input  logic [SAMPLE_W-1:0]         sample_re_i,
    input  logic [SAMPLE_W-1:0]         sample_im_i,
    input  logic                        sample_valid_i,
    input  logic [ofdm_pkg::CP_W-1:0]   cp_len_i,
    input  logic                        sync_i,
    output logic [SAMPLE_W-1:0]         sc_re_o,
    output logic [SAMPLE_W-1:0]         sc_im_o,
    output logic                        sc_valid_o,
    output logic                        sc_last_o,
    output ofdm_pkg::sym_kind_t         sc_kind_o,
    output logic [ofdm_pkg::SLOT_W-1:0] sc_slot_o,
    output logic [ofdm_pkg::SYM_W-1:0]  sc_idx_o,
    output logic                        overrun_o
);

    // decode to execute
    logic [SAMPLE_W-1:0]         sym_re;
    logic [SAMPLE_W-1:0]         sym_im;
    logic                        sym_valid;
    logic [ofdm_pkg::SLOT_W-1:0] sym_slot;
    logic [ofdm_pkg::SYM_W-1:0]  sym_idx;

    // execute to result
    logic [SAMPLE_W-1:0]         bin_re;
    logic [SAMPLE_W-1:0]         bin_im;
    logic                        bin_valid;
    logic [NFFT-1:0]             bin_pos;
    logic [ofdm_pkg::SLOT_W-1:0] bin_slot;
    logic [ofdm_pkg::SYM_W-1:0]  bin_idx;

    cp_remover #(
        .NFFT     (NFFT),
        .SAMPLE_W (SAMPLE_W)
    ) cp_remover_i (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_re_i    (sample_re_i),
        .sample_im_i    (sample_im_i),
        .sample_valid_i (sample_valid_i),
        .cp_len_i       (cp_len_i),
        .sync_i         (sync_i),
        .sym_re_o       (sym_re),
        .sym_im_o       (sym_im),
        .sym_valid_o    (sym_valid),
        .sym_slot_o     (sym_slot),
        .sym_idx_o      (sym_idx)
    );

    dft_engine #(
        .NFFT     (NFFT),
        .SAMPLE_W (SAMPLE_W)
    ) dft_engine_i (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .sym_re_i    (sym_re),
        .sym_im_i    (sym_im),
        .sym_valid_i (sym_valid),
        .sym_slot_i  (sym_slot),
        .sym_idx_i   (sym_idx),
        .bin_re_o    (bin_re),
        .bin_im_o    (bin_im),
        .bin_valid_o (bin_valid),
        .bin_pos_o   (bin_pos),
        .bin_slot_o  (bin_slot),
        .bin_idx_o   (bin_idx),
        .overrun_o   (overrun_o)
    );

    sc_mapper #(
        .NFFT     (NFFT),
        .SAMPLE_W (SAMPLE_W),
        .BAND_LEN (BAND_LEN),
        .SSS_LEN  (SSS_LEN)
    ) sc_mapper_i (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .bin_re_i    (bin_re),
        .bin_im_i    (bin_im),
        .bin_valid_i (bin_valid),
        .bin_pos_i   (bin_pos),
        .bin_slot_i  (bin_slot),
        .bin_idx_i   (bin_idx),
        .sc_re_o     (sc_re_o),
        .sc_im_o     (sc_im_o),
        .sc_valid_o  (sc_valid_o),
        .sc_last_o   (sc_last_o),
        .sc_kind_o   (sc_kind_o),
        .sc_slot_o   (sc_slot_o),
        .sc_idx_o    (sc_idx_o)
    );

endmodule

/* testbench/ofdm_demod_tb.sv */
`timescale 1ns/1ps

module ofdm_demod_tb;

    localparam int NFFT       = 4;
    localparam int SAMPLE_W   = 16;
    localparam int BAND_LEN   = 12;
    localparam int SSS_LEN    = 8;
    localparam int FFT_LEN    = 2 ** NFFT;
    localparam int BIN_CYCLES = FFT_LEN + 2;
    // last band position in shifted order
    localparam int BAND_LAST  = FFT_LEN / 2 - BAND_LEN / 2 + BAND_LEN - 1;
    // the engine still computes the bins above the band
    localparam int DRAIN      = (FFT_LEN - 1 - BAND_LAST) * BIN_CYCLES + 8;
    localparam int TIMEOUT    = 2000;

    logic                        clk_i;
    logic                        reset_ni;
    logic [SAMPLE_W-1:0]         sample_re_i;
    logic [SAMPLE_W-1:0]         sample_im_i;
    logic                        sample_valid_i;
    logic [ofdm_pkg::CP_W-1:0]   cp_len_i;
    logic                        sync_i;
    logic [SAMPLE_W-1:0]         sc_re_o;
    logic [SAMPLE_W-1:0]         sc_im_o;
    logic                        sc_valid_o;
    logic                        sc_last_o;
    ofdm_pkg::sym_kind_t         sc_kind_o;
    logic [ofdm_pkg::SLOT_W-1:0] sc_slot_o;
    logic [ofdm_pkg::SYM_W-1:0]  sc_idx_o;
    logic                        overrun_o;

    logic [31:0]                 lcg_state;
    logic signed [SAMPLE_W-1:0]  tx_re [FFT_LEN];
    logic signed [SAMPLE_W-1:0]  tx_im [FFT_LEN];
    logic signed [SAMPLE_W-1:0]  exp_re [BAND_LEN];
    logic signed [SAMPLE_W-1:0]  exp_im [BAND_LEN];
    logic signed [SAMPLE_W-1:0]  rx_re [BAND_LEN];
    logic signed [SAMPLE_W-1:0]  rx_im [BAND_LEN];
    logic                        rx_last [BAND_LEN];
    ofdm_pkg::sym_kind_t         rx_kind [BAND_LEN];
    logic [ofdm_pkg::SLOT_W-1:0] rx_slot [BAND_LEN];
    logic [ofdm_pkg::SYM_W-1:0]  rx_idx [BAND_LEN];

    // symbols sent since the last sync give the expected numbering
    int sym_count = 0;
    int valid_count = 0;
    int overrun_count = 0;

    ofdm_demod #(
        .NFFT     (NFFT),
        .SAMPLE_W (SAMPLE_W),
        .BAND_LEN (BAND_LEN),
        .SSS_LEN  (SSS_LEN)
    ) ofdm_demod_i (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sample_re_i    (sample_re_i),
        .sample_im_i    (sample_im_i),
        .sample_valid_i (sample_valid_i),
        .cp_len_i       (cp_len_i),
        .sync_i         (sync_i),
        .sc_re_o        (sc_re_o),
        .sc_im_o        (sc_im_o),
        .sc_valid_o     (sc_valid_o),
        .sc_last_o      (sc_last_o),
        .sc_kind_o      (sc_kind_o),
        .sc_slot_o      (sc_slot_o),
        .sc_idx_o       (sc_idx_o),
        .overrun_o      (overrun_o)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #2 clk_i = ~clk_i;
        end
    end

    // outputs are counted at the falling edge where they are stable
    always @(negedge clk_i) begin
        if (sc_valid_o) begin
            valid_count++;
        end
        if (overrun_o) begin
            overrun_count++;
        end
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // PBCH fills the whole band and SSS only its centre
    function automatic ofdm_pkg::sym_kind_t expected_kind(input int slot, input int idx,
                                                          input int band_i);
        if (slot == 0 && idx == ofdm_pkg::PBCH_SYM) begin
            return ofdm_pkg::SYM_PBCH;
        end
        if (slot == 0 && idx == ofdm_pkg::SSS_SYM && band_i >= (BAND_LEN - SSS_LEN) / 2 &&
            band_i < (BAND_LEN + SSS_LEN) / 2) begin
            return ofdm_pkg::SYM_SSS;
        end
        return ofdm_pkg::SYM_DATA;
    endfunction

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_sample(input string name, input logic signed [SAMPLE_W-1:0] exp_r,
                                input logic signed [SAMPLE_W-1:0] exp_i,
                                input logic signed [SAMPLE_W-1:0] act_r,
                                input logic signed [SAMPLE_W-1:0] act_i);
        int dr;
        int di;
        dr = int'(act_r) - int'(exp_r);
        di = int'(act_i) - int'(exp_i);
        // twiddle rounding allows a couple of LSB
        if (dr < -2 || dr > 2 || di < -2 || di > 2) begin
            stop_on_error($sformatf("ERROR %s: expected (%0d, %0d), actual (%0d, %0d)",
                                    name, exp_r, exp_i, act_r, act_i));
        end
    endtask

    task automatic check_kind(input string name, input ofdm_pkg::sym_kind_t exp_k,
                              input ofdm_pkg::sym_kind_t act_k);
        if (exp_k != act_k) begin
            stop_on_error($sformatf("ERROR %s: expected kind %s, actual kind %s",
                                    name, exp_k.name(), act_k.name()));
        end
    endtask

    task automatic check_meta(input string name, input logic [ofdm_pkg::SLOT_W-1:0] exp_slot,
                              input logic [ofdm_pkg::SYM_W-1:0] exp_idx,
                              input logic [ofdm_pkg::SLOT_W-1:0] act_slot,
                              input logic [ofdm_pkg::SYM_W-1:0] act_idx);
        if (exp_slot != act_slot || exp_idx != act_idx) begin
            stop_on_error($sformatf("ERROR %s: expected slot %0d sym %0d, actual slot %0d sym %0d",
                                    name, exp_slot, exp_idx, act_slot, act_idx));
        end
    endtask

    task automatic check_flag(input string name, input logic exp_f, input logic act_f);
        if (exp_f !== act_f) begin
            stop_on_error($sformatf("ERROR %s: expected %b, actual %b", name, exp_f, act_f));
        end
    endtask

    task automatic check_count(input string name, input int exp_n, input int act_n);
        if (exp_n != act_n) begin
            stop_on_error($sformatf("ERROR %s: expected %0d, actual %0d", name, exp_n, act_n));
        end
    endtask

    task automatic drive_sample(input logic [SAMPLE_W-1:0] re, input logic [SAMPLE_W-1:0] im,
                                input int cp);
        @(posedge clk_i);
        sample_re_i    <= re;
        sample_im_i    <= im;
        cp_len_i       <= ofdm_pkg::CP_W'(cp);
        sample_valid_i <= 1'b1;
    endtask

    task automatic idle_cycles(input int n);
        @(posedge clk_i);
        sample_valid_i <= 1'b0;
        sync_i         <= 1'b0;
        repeat (n - 1) @(posedge clk_i);
    endtask

    task automatic pulse_sync();
        @(posedge clk_i);
        sample_valid_i <= 1'b0;
        sync_i         <= 1'b1;
        @(posedge clk_i);
        sync_i         <= 1'b0;
        sym_count = 0;
    endtask

    // random cyclic prefix followed by the prepared symbol
    task automatic send_symbol(input int cp);
        logic [31:0] r;
        for (int i = 0; i < cp; i++) begin
            r = next_random();
            drive_sample(r[31:16], r[15:0], cp);
        end
        for (int n = 0; n < FFT_LEN; n++) begin
            drive_sample(tx_re[n], tx_im[n], cp);
        end
    endtask

    // an impulse x[0] = a puts a / N into every bin
    task automatic load_impulse(input int a_re, input int a_im);
        for (int n = 0; n < FFT_LEN; n++) begin
            tx_re[n] = (n == 0) ? SAMPLE_W'(a_re) : '0;
            tx_im[n] = (n == 0) ? SAMPLE_W'(a_im) : '0;
        end
        for (int i = 0; i < BAND_LEN; i++) begin
            exp_re[i] = SAMPLE_W'(a_re / FFT_LEN);
            exp_im[i] = SAMPLE_W'(a_im / FFT_LEN);
        end
    endtask

    task automatic load_constant(input int a_re, input int a_im);
        for (int n = 0; n < FFT_LEN; n++) begin
            tx_re[n] = SAMPLE_W'(a_re);
            tx_im[n] = SAMPLE_W'(a_im);
        end
        for (int i = 0; i < BAND_LEN; i++) begin
            exp_re[i] = (i == BAND_LEN / 2) ? SAMPLE_W'(a_re) : '0;
            exp_im[i] = (i == BAND_LEN / 2) ? SAMPLE_W'(a_im) : '0;
        end
    endtask

    task automatic collect_band(input string name);
        int waited;
        for (int i = 0; i < BAND_LEN; i++) begin
            waited = 0;
            @(negedge clk_i);
            while (!sc_valid_o) begin
                waited++;
                if (waited > TIMEOUT) begin
                    stop_on_error($sformatf("%s: timed out waiting for band bin %0d", name, i));
                end
                @(negedge clk_i);
            end
            rx_re[i]   = sc_re_o;
            rx_im[i]   = sc_im_o;
            rx_last[i] = sc_last_o;
            rx_kind[i] = sc_kind_o;
            rx_slot[i] = sc_slot_o;
            rx_idx[i]  = sc_idx_o;
        end
    endtask

    task automatic check_band(input string name, input int slot, input int idx);
        string tag;
        for (int i = 0; i < BAND_LEN; i++) begin
            tag = $sformatf("%s bin %0d", name, i);
            check_sample(tag, exp_re[i], exp_im[i], rx_re[i], rx_im[i]);
            check_meta(tag, ofdm_pkg::SLOT_W'(slot), ofdm_pkg::SYM_W'(idx), rx_slot[i], rx_idx[i]);
            check_kind(tag, expected_kind(slot, idx, i), rx_kind[i]);
            check_flag({tag, " last"}, i == BAND_LEN - 1, rx_last[i]);
        end
    endtask

    task automatic run_symbol(input string name, input int cp);
        int slot;
        int idx;
        int start_valid;
        int start_overrun;
        slot = (sym_count / ofdm_pkg::SYM_PER_SLOT) % ofdm_pkg::SLOTS_PER_FRAME;
        idx = sym_count % ofdm_pkg::SYM_PER_SLOT;
        start_valid = valid_count;
        start_overrun = overrun_count;
        send_symbol(cp);
        idle_cycles(1);
        collect_band(name);
        // let the engine finish the bins above the band
        idle_cycles(DRAIN);
        check_band(name, slot, idx);
        check_count({name, " bin count"}, BAND_LEN, valid_count - start_valid);
        check_count({name, " overrun count"}, 0, overrun_count - start_overrun);
        sym_count++;
    endtask

    task automatic test_reset_state();
        for (int i = 0; i < 20; i++) begin
            @(negedge clk_i);
            check_flag("reset_state sc_valid_o", 1'b0, sc_valid_o);
            check_flag("reset_state sc_last_o", 1'b0, sc_last_o);
            check_flag("reset_state overrun_o", 1'b0, overrun_o);
        end
    endtask

    task automatic test_impulse();
        load_impulse(1600, -800);
        run_symbol("impulse_cp4", 4);
        load_impulse(-2400, 3200);
        run_symbol("impulse_cp11", 11);
    endtask

    task automatic test_dc_symbol();
        load_constant(1000, 500);
        run_symbol("dc_symbol", 7);
    endtask

    task automatic test_numbering();
        logic [31:0] r;
        pulse_sync();
        for (int s = 0; s < ofdm_pkg::SYM_PER_SLOT + 1; s++) begin
            r = next_random();
            load_impulse(1600, -800);
            run_symbol($sformatf("numbering sym %0d", s), int'(r[23:16] % 10));
        end
    endtask

    task automatic test_sync_realign();
        logic [31:0] r;
        // part of a long prefix before the frame start
        for (int i = 0; i < 6; i++) begin
            r = next_random();
            drive_sample(r[31:16], r[15:0], 10);
        end
        pulse_sync();
        load_impulse(-1200, 700);
        run_symbol("sync_realign", 3);
    endtask

    task automatic test_overrun();
        int start_valid;
        int start_overrun;
        start_valid = valid_count;
        start_overrun = overrun_count;
        load_impulse(1600, -800);
        send_symbol(4);
        // second symbol lands while the first one is transformed
        load_constant(900, -300);
        send_symbol(4);
        idle_cycles(1);
        load_impulse(1600, -800);
        collect_band("overrun");
        idle_cycles(FFT_LEN * BIN_CYCLES + DRAIN);
        check_band("overrun", 0, sym_count);
        check_count("overrun bin count", BAND_LEN, valid_count - start_valid);
        check_count("overrun pulse count", 1, overrun_count - start_overrun);
        sym_count += 2;
    endtask

    initial begin
        reset_ni       = 1'b0;
        sample_re_i    = '0;
        sample_im_i    = '0;
        sample_valid_i = 1'b0;
        cp_len_i       = '0;
        sync_i         = 1'b0;
        lcg_state      = 32'h310ce010;
        repeat (3) @(posedge clk_i);
        reset_ni <= 1'b1;
        test_reset_state();
        test_impulse();
        test_dc_symbol();
        test_numbering();
        test_sync_realign();
        test_overrun();
        $display("** PASS **");
        $finish;
    end

endmodule

/* vlog.f */
source/ofdm_pkg.sv
source/cp_remover.sv
source/dft_engine.sv
source/sc_mapper.sv
source/ofdm_demod.sv
testbench/ofdm_demod_tb.sv

/* Makefile */
# Verilator build and run for the OFDM demodulator testbench

VERILATOR ?= verilator
TOP       ?= ofdm_demod_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' $(LOG); then echo "simulation did not complete"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
